//--- tests/golden_packets.txt
// line 1: router address, legal flit count, error flit count
// then per flit: head tail data_in route_op data_out, error flits last
9 d 2
1 0 a5a50059 02 a5a50059
0 0 11110003 00 11110003
0 1 2222000e 00 2222000e
1 0 3c3c0040 01 3c3c0044
0 1 44440007 00 44440007
1 0 5a5a0011 02 5a5a0012
0 0 55550006 00 55550006
0 0 66660005 00 66660005
0 1 77770004 00 77770004
1 0 0f0f006b 08 0f0f006c
0 1 88880001 00 88880001
1 0 c3c3004c 10 c3c3004c
0 1 99990002 00 99990002
0 0 bbbb0001 00 00000000
1 0 cccc004e 00 00000000

//--- input_port_ctrl.f
common/ipc_pkg.sv
common/in_flit_if.sv
common/head_flit_if.sv
flit_buffer/buffer_occupancy.sv
flit_buffer/flit_buffer.sv
logic/packet_tracker.sv
logic/route_lookahead.sv
logic/flit_output.sv
logic/input_port_ctrl.sv
tests/input_port_ctrl_properties.sv
tests/tb_input_port_ctrl.sv

//--- Bender.yml
package:
  name: input_port_ctrl

sources:
  - files:
      - common/ipc_pkg.sv
      - common/in_flit_if.sv
      - common/head_flit_if.sv
      - flit_buffer/buffer_occupancy.sv
      - flit_buffer/flit_buffer.sv
      - logic/packet_tracker.sv
      - logic/route_lookahead.sv
      - logic/flit_output.sv
      - logic/input_port_ctrl.sv
  - target: test
    files:
      - tests/input_port_ctrl_properties.sv
      - tests/tb_input_port_ctrl.sv

//--- tests/tb_input_port_ctrl.sv
// testbench for the input port controller with golden file stimulus, scoreboard and verdict
`timescale 1ns/1ns

module tb_input_port_ctrl;

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DELAY = 5;
   localparam int MAX_CYCLES = 2000;
   localparam int ERROR_WAIT = 20;
   // address, flit count, error flit count, then five words per flit
   localparam int GOLDEN_WORDS = 78;

   logic clk;
   logic rst;
   logic [ipc_pkg::ROUTER_ADDR_WIDTH-1:0] router_address;
   logic flit_valid_in;
   logic flit_head_in;
   logic flit_tail_in;
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] flit_data_in;
   logic gnt;
   logic [ipc_pkg::NUM_PORTS-1:0] route_op;
   logic req;
   logic req_head;
   logic req_tail;
   logic flit_valid_out;
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] flit_data_out;
   logic flow_ctrl_out;
   logic error;

   logic [31:0] golden [0:GOLDEN_WORDS-1];
   int num_flits;
   int num_err_flits;
   // next flit expected at the request head and at the output
   int req_idx;
   int out_idx;
   int credits;
   int credit_pulses;
   int errors;
   int checks;
   bit scoreboard_on;

   input_port_ctrl uut (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD/2) clk = ~clk;

   // word of one flit record: 0 head, 1 tail, 2 data in, 3 route_op, 4 data out
   function automatic logic [31:0] golden_field(input int flit, input int field);
      return golden[3 + 5*flit + field];
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
   endtask

   task automatic drive_flit(input int idx);
      flit_valid_in = 1'b1;
      flit_head_in  = golden_field(idx, 0) != 0;
      flit_tail_in  = golden_field(idx, 1) != 0;
      flit_data_in  = golden_field(idx, 2);
   endtask

   // ------------------------------------------------------------
   // scoreboard, sampled mid cycle
   // ------------------------------------------------------------
   always @(negedge clk)
   begin
      if (scoreboard_on)
      begin
         checks++;
         if (req && req_idx >= num_flits)
         begin
            errors++;
            $display("Error at %0t ns: request raised with no flit outstanding", $time);
         end
         else if (req)
         begin
            if (32'(req_head) !== golden_field(req_idx, 0))
               report_mismatch("req_head", 32'(req_head), golden_field(req_idx, 0));
            if (32'(req_tail) !== golden_field(req_idx, 1))
               report_mismatch("req_tail", 32'(req_tail), golden_field(req_idx, 1));
            if (32'(route_op) !== golden_field(req_idx, 3))
               report_mismatch("route_op", 32'(route_op), golden_field(req_idx, 3));
            if (gnt)
               req_idx++;
         end
         else if (route_op !== '0)
            report_mismatch("route_op", 32'(route_op), 32'd0);
         // departing flit, order must match the golden order
         if (flit_valid_out && out_idx >= num_flits)
         begin
            errors++;
            $display("Error at %0t ns: flit left with none outstanding", $time);
         end
         else if (flit_valid_out)
         begin
            if (flit_data_out !== golden_field(out_idx, 4))
               report_mismatch("flit_data_out", flit_data_out, golden_field(out_idx, 4));
            out_idx++;
         end
         if (flow_ctrl_out !== flit_valid_out)
            report_mismatch("flow_ctrl_out", 32'(flow_ctrl_out), 32'(flit_valid_out));
         if (flow_ctrl_out)
            credit_pulses++;
         if (error !== 1'b0)
            report_mismatch("error", 32'(error), 32'd0);
      end
   end

   // ------------------------------------------------------------
   // legal traffic under random grants
   // ------------------------------------------------------------
   task automatic run_traffic(output bit done);
      int sent;
      int cycles;
      sent = 0;
      cycles = 0;
      done = 1'b0;
      scoreboard_on = 1'b1;
      while (!done && cycles < MAX_CYCLES)
      begin
         @(posedge clk);
         #DRIVE_DELAY;
         // credit returned by the flit leaving this cycle
         if (flow_ctrl_out)
            credits++;
         gnt = req & 1'($urandom);
         flit_valid_in = 1'b0;
         if (sent < num_flits && credits > 0)
         begin
            drive_flit(sent);
            credits--;
            sent++;
         end
         cycles++;
         done = (sent == num_flits) && (out_idx == num_flits);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      gnt = 1'b0;
      flit_valid_in = 1'b0;
      scoreboard_on = 1'b0;
   endtask

   // one illegal flit after reset, error must rise and hold
   task automatic run_error_case(input int k);
      int cycles;
      apply_reset();
      checks++;
      if (error !== 1'b0)
         report_mismatch("error", 32'(error), 32'd0);
      drive_flit(num_flits + k);
      @(posedge clk);
      #DRIVE_DELAY;
      flit_valid_in = 1'b0;
      cycles = 0;
      while (error !== 1'b1 && cycles < ERROR_WAIT)
      begin
         @(posedge clk);
         #DRIVE_DELAY;
         cycles++;
      end
      if (error !== 1'b1)
      begin
         errors++;
         $display("Error case %0d: the error flag never went high", k);
      end
      else
      begin
         repeat (10)
         begin
            @(posedge clk);
            #DRIVE_DELAY;
            checks++;
            if (error !== 1'b1)
               report_mismatch("error", 32'(error), 32'd1);
         end
      end
   endtask

   initial
   begin
      bit traffic_done;
      void'($urandom(22680));
      rst = 1'b1;
      router_address = '0;
      flit_valid_in = 1'b0;
      flit_head_in = 1'b0;
      flit_tail_in = 1'b0;
      flit_data_in = '0;
      gnt = 1'b0;
      scoreboard_on = 1'b0;
      req_idx = 0;
      out_idx = 0;
      credit_pulses = 0;
      errors = 0;
      checks = 0;
      credits = ipc_pkg::BUFFER_DEPTH;
      $readmemh("tests/golden_packets.txt", golden);
      router_address = golden[0][ipc_pkg::ROUTER_ADDR_WIDTH-1:0];
      num_flits = golden[1];
      num_err_flits = golden[2];
      apply_reset();
      run_traffic(traffic_done);
      if (!traffic_done)
      begin
         errors++;
         $display("Timeout: only %0d of %0d flits left the port", out_idx, num_flits);
      end
      else
      begin
         checks += 2;
         if (credit_pulses != num_flits)
            report_mismatch("credit pulses", credit_pulses, num_flits);
         if (credits != ipc_pkg::BUFFER_DEPTH)
            report_mismatch("credits", credits, ipc_pkg::BUFFER_DEPTH);
         for (int k = 0; k < num_err_flits; k++)
            run_error_case(k);
         // only reset clears the sticky flag
         apply_reset();
         checks++;
         if (error !== 1'b0)
            report_mismatch("error", 32'(error), 32'd0);
      end
      checks++;
      if (uut.props.fail_count != 0)
      begin
         errors += uut.props.fail_count;
         $display("Error: %0d concurrent assertions failed in the bound checker",
                  uut.props.fail_count);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- tests/input_port_ctrl_properties.sv
// concurrent assertions on reset, credit timing, route decode and the sticky error
`timescale 1ns/1ns

module input_port_ctrl_properties (
   input logic clk,
   input logic rst,
   input logic gnt,
   input logic req,
   input logic flow_ctrl_out,
   input logic [ipc_pkg::NUM_PORTS-1:0] route_op,
   input logic error
);

   // number of failed assertions so far
   int fail_count = 0;

   // ------------------------------------------------------------
   // reset and credit timing
   // ------------------------------------------------------------
   assert property (@(posedge clk) rst |=> (!req && !flow_ctrl_out))
      else
      begin
         $error("req or flow_ctrl_out high right after reset");
         fail_count++;
      end

   // credit goes back exactly one cycle after the grant
   assert property (@(posedge clk) disable iff (rst) gnt |=> flow_ctrl_out)
      else
      begin
         $error("no credit one cycle after a grant");
         fail_count++;
      end
   assert property (@(posedge clk) disable iff (rst) !gnt |=> !flow_ctrl_out)
      else
      begin
         $error("credit without a grant in the cycle before");
         fail_count++;
      end

   // ------------------------------------------------------------
   // decode and error flag
   // ------------------------------------------------------------
   assert property (@(posedge clk) $onehot0(route_op))
      else
      begin
         $error("route_op has more than one bit set");
         fail_count++;
      end

   assert property (@(posedge clk) (error && !rst) |=> error)
      else
      begin
         $error("error flag fell without reset");
         fail_count++;
      end

endmodule

bind input_port_ctrl input_port_ctrl_properties props (
   .clk(clk), .rst(rst), .gnt(gnt), .req(req), .flow_ctrl_out(flow_ctrl_out),
   .route_op(route_op), .error(error)
);

//--- logic/input_port_ctrl.sv
// input port controller top level with plain ports and block wiring
`timescale 1ns/1ns

module input_port_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic [ipc_pkg::ROUTER_ADDR_WIDTH-1:0] router_address,
   input  logic flit_valid_in,
   input  logic flit_head_in,
   input  logic flit_tail_in,
   input  logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] flit_data_in,
   input  logic gnt,
   output logic [ipc_pkg::NUM_PORTS-1:0] route_op,
   output logic req,
   output logic req_head,
   output logic req_tail,
   output logic flit_valid_out,
   output logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] flit_data_out,
   output logic flow_ctrl_out,
   output logic error
);

   logic fb_empty, fb_full;
   logic overflow, underflow, invalid_port;
   logic [ipc_pkg::PORT_IDX_WIDTH-1:0] next_lar;

   // ------------------------------------------------------------
   // link and head views
   // ------------------------------------------------------------
   in_flit_if   in_flit ();
   head_flit_if head ();

   assign in_flit.valid = flit_valid_in;
   assign in_flit.head  = flit_head_in;
   assign in_flit.tail  = flit_tail_in;
   assign in_flit.data  = flit_data_in;
   // grant pops the head flit
   assign head.pop = gnt;

   // ------------------------------------------------------------
   // blocks
   // ------------------------------------------------------------
   buffer_occupancy occ (.clk(clk), .rst(rst), .push(flit_valid_in), .pop(gnt),
      .empty(fb_empty), .full(fb_full), .overflow(overflow), .underflow(underflow));

   flit_buffer fb (.clk(clk), .rst(rst), .in_flit(in_flit), .head(head),
      .empty(fb_empty), .full(fb_full));

   packet_tracker trk (.clk(clk), .rst(rst), .in_flit(in_flit), .head(head),
      .overflow(overflow), .underflow(underflow), .invalid_port(invalid_port),
      .req_head(req_head), .error(error));

   route_lookahead lar (.router_address(router_address), .head(head),
      .req_head(req_head), .route_op(route_op), .next_lar(next_lar),
      .invalid_port(invalid_port));

   flit_output fo (.clk(clk), .rst(rst), .head(head), .req_head(req_head),
      .next_lar(next_lar), .flit_valid_out(flit_valid_out),
      .flow_ctrl_out(flow_ctrl_out), .flit_data_out(flit_data_out));

   // allocator request from the buffer head
   assign req      = head.valid;
   assign req_tail = head.valid & head.tail;

endmodule

//--- logic/flit_output.sv
// output registers for departing flit data, valid and credit
`timescale 1ns/1ns

module flit_output (
   input  logic clk,
   input  logic rst,
   head_flit_if.peek head,
   input  logic req_head,
   input  logic [ipc_pkg::PORT_IDX_WIDTH-1:0] next_lar,
   output logic flit_valid_out,
   output logic flow_ctrl_out,
   output logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] flit_data_out
);

   logic pop_ok;
   logic depart_q;
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] data_next;
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] data_q;

   // a flit leaves only if the buffer really held one
   assign pop_ok = head.valid & head.pop;

   // head flits carry the port for the next router
   always_comb
   begin
      data_next = head.data;
      if (req_head)
         data_next[ipc_pkg::LAR_LSB +: ipc_pkg::PORT_IDX_WIDTH] = next_lar;
   end

   always_ff @(posedge clk)
   begin
      if (pop_ok)
         data_q <= data_next;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         depart_q <= 1'b0;
      else
         depart_q <= pop_ok;
   end

   // one credit per departing flit, same cycle as the flit
   assign flit_valid_out = depart_q;
   assign flow_ctrl_out  = depart_q;
   assign flit_data_out  = data_q;

endmodule

//--- logic/route_lookahead.sv
// lookahead port decode, next router address and next hop dimension order routing
`timescale 1ns/1ns

module route_lookahead (
   input  logic [ipc_pkg::ROUTER_ADDR_WIDTH-1:0] router_address,
   head_flit_if.peek head,
   input  logic req_head,
   output logic [ipc_pkg::NUM_PORTS-1:0] route_op,
   output logic [ipc_pkg::PORT_IDX_WIDTH-1:0] next_lar,
   output logic invalid_port
);

   logic [ipc_pkg::PORT_IDX_WIDTH-1:0] lar;
   logic [ipc_pkg::ROUTER_ADDR_WIDTH-1:0] dest;
   logic active;
   logic [ipc_pkg::DIM_ADDR_WIDTH-1:0] cur_x, cur_y;
   logic [ipc_pkg::DIM_ADDR_WIDTH-1:0] nxt_x, nxt_y;
   logic [ipc_pkg::DIM_ADDR_WIDTH-1:0] dst_x, dst_y;
   ipc_pkg::port_e next_port;

   // header fields of the head flit
   assign lar  = head.data[ipc_pkg::LAR_LSB +: ipc_pkg::PORT_IDX_WIDTH];
   assign dest = head.data[ipc_pkg::DEST_LSB +: ipc_pkg::ROUTER_ADDR_WIDTH];

   // ------------------------------------------------------------
   // port decode for the switch allocator
   // ------------------------------------------------------------
   assign active       = head.valid & req_head;
   assign invalid_port = active & (lar >= ipc_pkg::PORT_IDX_WIDTH'(ipc_pkg::NUM_PORTS));
   assign route_op     = (active & ~invalid_port) ?
                         (ipc_pkg::NUM_PORTS'(1) << lar) : '0;

   // ------------------------------------------------------------
   // next router address, one hop along the lookahead port
   // ------------------------------------------------------------
   assign cur_x = router_address[0 +: ipc_pkg::DIM_ADDR_WIDTH];
   assign cur_y = router_address[ipc_pkg::DIM_ADDR_WIDTH +: ipc_pkg::DIM_ADDR_WIDTH];
   assign dst_x = dest[0 +: ipc_pkg::DIM_ADDR_WIDTH];
   assign dst_y = dest[ipc_pkg::DIM_ADDR_WIDTH +: ipc_pkg::DIM_ADDR_WIDTH];

   always_comb
   begin
      nxt_x = cur_x;
      nxt_y = cur_y;
      case (lar)
         ipc_pkg::PORT_XM: nxt_x = cur_x - 1'b1;
         ipc_pkg::PORT_XP: nxt_x = cur_x + 1'b1;
         ipc_pkg::PORT_YM: nxt_y = cur_y - 1'b1;
         ipc_pkg::PORT_YP: nxt_y = cur_y + 1'b1;
         // local and illegal codes stay put
         default: ;
      endcase
   end

   // ------------------------------------------------------------
   // port at the next router, x first then y
   // ------------------------------------------------------------
   always_comb
   begin
      if (dst_x != nxt_x)
         next_port = (dst_x < nxt_x) ? ipc_pkg::PORT_XM : ipc_pkg::PORT_XP;
      else if (dst_y != nxt_y)
         next_port = (dst_y < nxt_y) ? ipc_pkg::PORT_YM : ipc_pkg::PORT_YP;
      else
         next_port = ipc_pkg::PORT_LOCAL;
   end

   assign next_lar = next_port;

endmodule

//--- logic/packet_tracker.sv
// input and output framing state machines and the sticky error register
`timescale 1ns/1ns

module packet_tracker (
   input  logic     clk,
   input  logic     rst,
   in_flit_if.sink  in_flit,
   head_flit_if.peek head,
   input  logic     overflow,
   input  logic     underflow,
   input  logic     invalid_port,
   output logic     req_head,
   output logic     error
);

   ipc_pkg::in_state_e  in_state;
   ipc_pkg::out_state_e out_state;
   logic invalid_flit_type;
   logic [ipc_pkg::ERR_COUNT-1:0] err_vec;
   logic error_q;

   // ------------------------------------------------------------
   // input side framing
   // ------------------------------------------------------------

   // head inside a packet, or body/tail with no packet open
   assign invalid_flit_type = in_flit.valid &
      ((in_flit.head & (in_state == ipc_pkg::IN_PACKET)) |
       (~in_flit.head & (in_state == ipc_pkg::IN_IDLE)));

   always_ff @(posedge clk)
   begin
      if (rst)
         in_state <= ipc_pkg::IN_IDLE;
      else if (in_flit.valid)
      begin
         // tail always closes, a head opens a new packet
         if (in_flit.tail)
            in_state <= ipc_pkg::IN_IDLE;
         else if (in_flit.head)
            in_state <= ipc_pkg::IN_PACKET;
      end
   end

   // ------------------------------------------------------------
   // output side framing
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (rst)
         out_state <= ipc_pkg::OUT_HEAD;
      else if (head.pop & head.valid)
         out_state <= head.tail ? ipc_pkg::OUT_HEAD : ipc_pkg::OUT_BODY;
   end

   // first flit after a tail is the next head
   assign req_head = head.valid & (out_state == ipc_pkg::OUT_HEAD);

   // ------------------------------------------------------------
   // sticky error collection
   // ------------------------------------------------------------
   assign err_vec = {invalid_flit_type, invalid_port, underflow, overflow};

   always_ff @(posedge clk)
   begin
      if (rst)
         error_q <= 1'b0;
      else
         error_q <= error_q | (|err_vec);
   end

   assign error = error_q;

endmodule

//--- flit_buffer/flit_buffer.sv
// circular flit store with write and read pointers and the head view
`timescale 1ns/1ns

module flit_buffer (
   input logic     clk,
   input logic     rst,
   in_flit_if.sink in_flit,
   head_flit_if.source head,
   input logic     empty,
   input logic     full
);

   // payload and tail bit per entry
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] data_mem [ipc_pkg::BUFFER_DEPTH];
   logic tail_mem [ipc_pkg::BUFFER_DEPTH];

   logic [ipc_pkg::PTR_WIDTH-1:0] wr_ptr;
   logic [ipc_pkg::PTR_WIDTH-1:0] rd_ptr;
   logic push_ok;
   logic pop_ok;

   // a push while full is dropped, counted as overflow elsewhere
   assign push_ok = in_flit.valid & ~full;
   assign pop_ok  = head.pop & ~empty;

   // ------------------------------------------------------------
   // storage
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         data_mem[wr_ptr] <= in_flit.data;
         tail_mem[wr_ptr] <= in_flit.tail;
      end
   end

   // pointers wrap on their own since depth is a power of two
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_ok)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // head view, straight from the read pointer
   assign head.valid = ~empty;
   assign head.tail  = tail_mem[rd_ptr];
   assign head.data  = data_mem[rd_ptr];

endmodule

//--- flit_buffer/buffer_occupancy.sv
// occupancy counter with empty and full flags and overflow and underflow pulses
`timescale 1ns/1ns

module buffer_occupancy (
   input  logic clk,
   input  logic rst,
   input  logic push,
   input  logic pop,
   output logic empty,
   output logic full,
   output logic overflow,
   output logic underflow
);

   logic [ipc_pkg::COUNT_WIDTH-1:0] count;

   assign empty = (count == '0);
   assign full  = (count == ipc_pkg::COUNT_WIDTH'(ipc_pkg::BUFFER_DEPTH));

   // illegal requests, the counter holds for these
   assign overflow  = push & full;
   assign underflow = pop & empty;

   // up/down count of accepted pushes and pops
   always_ff @(posedge clk)
   begin
      if (rst)
         count <= '0;
      else
      begin
         case ({push & ~full, pop & ~empty})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- common/head_flit_if.sv
// interface for the flit at the buffer head and its pop
`timescale 1ns/1ns

interface head_flit_if;

   // buffer holds at least one flit
   logic valid;
   logic tail;
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] data;
   // switch grant, removes the head flit at the clock edge
   logic pop;

   // driven by the flit buffer
   modport source (
      output valid,
      output tail,
      output data,
      input  pop
   );

   // observers of the head flit
   modport peek (
      input valid,
      input tail,
      input data,
      input pop
   );

endinterface

//--- common/in_flit_if.sv
// interface for the arriving flit stream
`timescale 1ns/1ns

interface in_flit_if;

   // flit present on the link this cycle
   logic valid;
   // framing flags
   logic head;
   logic tail;
   logic [ipc_pkg::FLIT_DATA_WIDTH-1:0] data;

   // no ready, the sender only transmits while it holds a credit
   modport sink (
      input valid,
      input head,
      input tail,
      input data
   );

endinterface

//--- common/ipc_pkg.sv
// sizes, flit field positions, port enum and framing state enums
package ipc_pkg;

   // ------------------------------------------------------------
   // flit and buffer sizes
   // ------------------------------------------------------------

   // payload bits per flit
   localparam int FLIT_DATA_WIDTH = 32;
   // buffer entries, also the upstream credit count after reset
   localparam int BUFFER_DEPTH = 8;
   localparam int PTR_WIDTH = 3;
   // one extra bit so that a full buffer can be counted
   localparam int COUNT_WIDTH = 4;

   // ------------------------------------------------------------
   // router geometry and flit header fields
   // ------------------------------------------------------------

   // four mesh neighbours plus one local node
   localparam int NUM_PORTS = 5;
   localparam int PORT_IDX_WIDTH = 3;
   // 4x4 mesh, x coordinate sits in the low half of the address
   localparam int DIM_ADDR_WIDTH = 2;
   localparam int ROUTER_ADDR_WIDTH = 4;
   // lookahead port code, then destination router address
   localparam int LAR_LSB = 0;
   localparam int DEST_LSB = 3;

   // overflow, underflow, invalid port, invalid flit type
   localparam int ERR_COUNT = 4;

   // output port codes, 5 to 7 are illegal
   typedef enum logic [PORT_IDX_WIDTH-1:0] {
      PORT_XM    = 3'd0,
      PORT_XP    = 3'd1,
      PORT_YM    = 3'd2,
      PORT_YP    = 3'd3,
      PORT_LOCAL = 3'd4
   } port_e;

   // framing of arriving flits
   typedef enum logic {IN_IDLE, IN_PACKET} in_state_e;

   // framing of departing flits
   typedef enum logic {OUT_HEAD, OUT_BODY} out_state_e;

endpackage
